// ==== verilog/bpu_cfg.svh ====
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// table geometry, 1024 entries per table
`define BPU_INDEX_BITS 10
// history length must match the index width, the two are xor'd
`define BPU_HIST_BITS 10

// counter value out of reset (weakly taken)
`define BPU_CTR_INIT 2

// statistics register byte offsets
`define STATS_TOTAL_ADDR 4'h0
`define STATS_CORRECT_ADDR 4'h4
`define STATS_CTRL_ADDR 4'h8

`endif

// ==== verilog/bpu_types_pkg.sv ====
`include "bpu_cfg.svh"

package bpu_types_pkg;

    typedef logic [31:0] pc_t;                    // instruction address
    typedef logic [`BPU_HIST_BITS-1:0] hist_t;    // per-branch outcome pattern
    typedef logic [`BPU_INDEX_BITS-1:0] table_index_t;
    typedef logic [1:0] sat_ctr_t;                // two-bit saturating counter
    typedef logic [31:0] count_t;                 // statistics counter value

    // answer to a fetch query
    typedef struct packed {
        logic taken;
        pc_t  target;
    } prediction_t;

    // branch outcome reported by execute
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
        pc_t  target;
        logic correct;    // execute saw a correct prediction
    } resolve_t;

endpackage

// ==== verilog/bpu_apb_pkg.sv ====
package bpu_apb_pkg;

    // byte offset inside the statistics register block
    typedef logic [3:0] stat_addr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        stat_addr_t  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // bus phase as seen by the slave
    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_phase_e;

endpackage

// ==== verilog/local_history_table.sv ====
`include "bpu_cfg.svh"

module local_history_table (
    input  logic                    clk,
    input  logic                    reset,
    input  bpu_types_pkg::pc_t      fetch_pc,
    input  bpu_types_pkg::resolve_t resolve,
    output bpu_types_pkg::hist_t    fetch_hist,
    output bpu_types_pkg::hist_t    resolve_hist
);

    localparam int ENTRIES = 1 << `BPU_INDEX_BITS;

    bpu_types_pkg::hist_t        hist_tbl [ENTRIES];
    bpu_types_pkg::table_index_t fetch_idx;
    bpu_types_pkg::table_index_t resolve_idx;

    // word-aligned pc, drop the byte offset
    assign fetch_idx   = fetch_pc[`BPU_INDEX_BITS+1:2];
    assign resolve_idx = resolve.pc[`BPU_INDEX_BITS+1:2];

    // two combinational read ports
    assign fetch_hist   = hist_tbl[fetch_idx];
    assign resolve_hist = hist_tbl[resolve_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                hist_tbl[i] <= '0;
            end
        end else if (resolve.valid) begin
            // newest outcome enters at bit 0
            hist_tbl[resolve_idx] <= {resolve_hist[`BPU_HIST_BITS-2:0], resolve.taken};
        end
    end

    // execute only ever reports instruction addresses
    resolve_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        resolve.valid |-> (resolve.pc[1:0] == 2'b00)
    );

endmodule

// ==== verilog/pattern_table.sv ====
`include "bpu_cfg.svh"

module pattern_table (
    input  logic                    clk,
    input  logic                    reset,
    input  bpu_types_pkg::pc_t      fetch_pc,
    input  bpu_types_pkg::hist_t    fetch_hist,
    input  bpu_types_pkg::resolve_t resolve,
    input  bpu_types_pkg::hist_t    resolve_hist,
    output logic                    counter_taken
);

    localparam int ENTRIES = 1 << `BPU_INDEX_BITS;

    bpu_types_pkg::sat_ctr_t     ctr_tbl [ENTRIES];
    bpu_types_pkg::table_index_t fetch_idx;
    bpu_types_pkg::table_index_t resolve_idx;
    bpu_types_pkg::sat_ctr_t     fetch_ctr;
    bpu_types_pkg::sat_ctr_t     resolve_ctr;
    bpu_types_pkg::sat_ctr_t     next_ctr;

    // history hashed with the low pc bits
    assign fetch_idx   = fetch_hist ^ fetch_pc[`BPU_INDEX_BITS+1:2];
    assign resolve_idx = resolve_hist ^ resolve.pc[`BPU_INDEX_BITS+1:2];

    assign fetch_ctr     = ctr_tbl[fetch_idx];
    assign resolve_ctr   = ctr_tbl[resolve_idx];
    assign counter_taken = fetch_ctr[1];    // upper bit is the direction

    // one saturating step toward the outcome
    always_comb begin
        next_ctr = resolve_ctr;
        if (resolve.taken && resolve_ctr != 2'b11)
            next_ctr = resolve_ctr + 2'd1;
        else if (!resolve.taken && resolve_ctr != 2'b00)
            next_ctr = resolve_ctr - 2'd1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_tbl[i] <= bpu_types_pkg::sat_ctr_t'(`BPU_CTR_INIT);
            end
        end else if (resolve.valid) begin
            ctr_tbl[resolve_idx] <= next_ctr;
        end
    end

endmodule

// ==== verilog/target_buffer.sv ====
`include "bpu_cfg.svh"

module target_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  bpu_types_pkg::pc_t         fetch_pc,
    input  logic                       counter_taken,
    input  bpu_types_pkg::resolve_t    resolve,
    output bpu_types_pkg::prediction_t prediction
);

    localparam int ENTRIES = 1 << `BPU_INDEX_BITS;

    bpu_types_pkg::pc_t          target_tbl [ENTRIES];
    logic                        valid_tbl [ENTRIES];
    bpu_types_pkg::table_index_t fetch_idx;
    bpu_types_pkg::table_index_t resolve_idx;
    logic                        fetch_valid;

    assign fetch_idx   = fetch_pc[`BPU_INDEX_BITS+1:2];
    assign resolve_idx = resolve.pc[`BPU_INDEX_BITS+1:2];
    assign fetch_valid = valid_tbl[fetch_idx];

    // only predict taken when there is a target to go to
    assign prediction.taken  = counter_taken && fetch_valid;
    assign prediction.target = fetch_valid ? target_tbl[fetch_idx] : fetch_pc + 32'd4;

    // a not-taken resolve drops the entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_tbl[i] <= 1'b0;
            end
        end else if (resolve.valid) begin
            valid_tbl[resolve_idx] <= resolve.taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && resolve.valid)
            target_tbl[resolve_idx] <= resolve.taken ? resolve.target
                                                     : resolve.pc + 32'd4;
    end

    // taken predictions land on instruction addresses
    taken_target_aligned: assert property (
        @(posedge clk) disable iff (reset)
        prediction.taken |-> (prediction.target[1:0] == 2'b00)
    );

endmodule

// ==== verilog/prediction_stats.sv ====
`include "bpu_cfg.svh"

module prediction_stats (
    input  logic                    clk,
    input  logic                    reset,
    input  bpu_types_pkg::resolve_t resolve,
    input  bpu_apb_pkg::apb_req_t   apb_req,
    output bpu_apb_pkg::apb_rsp_t   apb_rsp
);

    bpu_types_pkg::count_t   total_cnt;
    bpu_types_pkg::count_t   correct_cnt;
    bpu_apb_pkg::apb_phase_e cur_phase;
    bpu_apb_pkg::apb_phase_e last_phase;
    logic                    access_valid;
    logic                    addr_hit;
    logic                    clear;

    // phase of the current bus cycle
    always_comb begin
        if (!apb_req.psel)
            cur_phase = bpu_apb_pkg::idle;
        else if (!apb_req.penable)
            cur_phase = bpu_apb_pkg::setup;
        else
            cur_phase = bpu_apb_pkg::access;
    end

    always_ff @(posedge clk) begin
        if (reset)
            last_phase <= bpu_apb_pkg::idle;
        else
            last_phase <= cur_phase;
    end

    // zero wait states, every access completes at once
    assign access_valid = (cur_phase == bpu_apb_pkg::access)
                       && (last_phase == bpu_apb_pkg::setup);

    assign addr_hit = (apb_req.paddr == `STATS_TOTAL_ADDR)
                   || (apb_req.paddr == `STATS_CORRECT_ADDR)
                   || (apb_req.paddr == `STATS_CTRL_ADDR);

    assign clear = access_valid && apb_req.pwrite && apb_req.pwdata[0]
                && (apb_req.paddr == `STATS_CTRL_ADDR);

    always_ff @(posedge clk) begin
        if (reset || clear) begin    // clear beats a same-edge resolve
            total_cnt   <= '0;
            correct_cnt <= '0;
        end else if (resolve.valid) begin
            total_cnt <= total_cnt + 32'd1;
            if (resolve.correct)
                correct_cnt <= correct_cnt + 32'd1;
        end
    end

    assign apb_rsp.pready  = access_valid;
    assign apb_rsp.pslverr = access_valid && !addr_hit;

    always_comb begin
        apb_rsp.prdata = '0;
        if (access_valid && !apb_req.pwrite) begin
            case (apb_req.paddr)
                `STATS_TOTAL_ADDR:   apb_rsp.prdata = total_cnt;
                `STATS_CORRECT_ADDR: apb_rsp.prdata = correct_cnt;
                default:             apb_rsp.prdata = '0;    // ctrl reads as zero
            endcase
        end
    end

    correct_within_total: assert property (
        @(posedge clk) disable iff (reset) correct_cnt <= total_cnt
    );

    enable_after_setup: assert property (
        @(posedge clk) disable iff (reset)
        (apb_req.psel && apb_req.penable) |-> (last_phase == bpu_apb_pkg::setup)
    );

endmodule

// ==== verilog/branch_predictor_top.sv ====
module branch_predictor_top (
    input  logic                       clk,
    input  logic                       reset,
    input  bpu_types_pkg::pc_t         fetch_pc,
    output bpu_types_pkg::prediction_t prediction,
    input  bpu_types_pkg::resolve_t    resolve,
    input  bpu_apb_pkg::apb_req_t      apb_req,
    output bpu_apb_pkg::apb_rsp_t      apb_rsp
);

    bpu_types_pkg::hist_t fetch_hist;
    bpu_types_pkg::hist_t resolve_hist;
    logic                 counter_taken;

    local_history_table local_history_table_inst (
        .clk          (clk),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .resolve      (resolve),
        .fetch_hist   (fetch_hist),
        .resolve_hist (resolve_hist)
    );

    pattern_table pattern_table_inst (
        .clk           (clk),
        .reset         (reset),
        .fetch_pc      (fetch_pc),
        .fetch_hist    (fetch_hist),
        .resolve       (resolve),
        .resolve_hist  (resolve_hist),
        .counter_taken (counter_taken)
    );

    target_buffer target_buffer_inst (
        .clk           (clk),
        .reset         (reset),
        .fetch_pc      (fetch_pc),
        .counter_taken (counter_taken),
        .resolve       (resolve),
        .prediction    (prediction)
    );

    prediction_stats prediction_stats_inst (
        .clk     (clk),
        .reset   (reset),
        .resolve (resolve),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

// ==== tests/bpu_tb.sv ====
`include "bpu_cfg.svh"

module bpu_tb;

    localparam int ENTRIES       = 1 << `BPU_INDEX_BITS;
    localparam int RANDOM_CYCLES = 2000;
    localparam int APB_TIMEOUT   = 20;
    localparam bpu_types_pkg::resolve_t NO_RESOLVE = '0;

    logic                       clk;
    logic                       reset;
    bpu_types_pkg::pc_t         fetch_pc;
    bpu_types_pkg::prediction_t prediction;
    bpu_types_pkg::resolve_t    resolve;
    bpu_apb_pkg::apb_req_t      apb_req;
    bpu_apb_pkg::apb_rsp_t      apb_rsp;

    // reference model state
    bpu_types_pkg::hist_t    hist_model [ENTRIES];
    bpu_types_pkg::sat_ctr_t ctr_model [ENTRIES];
    logic                    valid_model [ENTRIES];
    bpu_types_pkg::pc_t      target_model [ENTRIES];
    bpu_types_pkg::count_t   total_model;
    bpu_types_pkg::count_t   correct_model;

    bpu_types_pkg::pc_t pc_pool [8];    // entries i and i+4 alias
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_start_errors;
    logic [31:0] rdata;
    logic        slverr;

    branch_predictor_top branch_predictor_top_inst (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .prediction (prediction),
        .resolve    (resolve),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic end_test(input string title);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, title, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    function automatic bpu_types_pkg::prediction_t expected_prediction(
        input bpu_types_pkg::pc_t pc
    );
        bpu_types_pkg::prediction_t  p;
        bpu_types_pkg::table_index_t idx;
        bpu_types_pkg::table_index_t cidx;
        idx      = pc[`BPU_INDEX_BITS+1:2];
        cidx     = hist_model[idx] ^ idx;
        p.taken  = ctr_model[cidx][1] & valid_model[idx];
        p.target = valid_model[idx] ? target_model[idx] : pc + 32'd4;
        return p;
    endfunction

    task automatic apply_resolve(input bpu_types_pkg::resolve_t r);
        bpu_types_pkg::table_index_t idx;
        bpu_types_pkg::table_index_t cidx;
        if (r.valid) begin
            idx  = r.pc[`BPU_INDEX_BITS+1:2];
            cidx = hist_model[idx] ^ idx;    // old history selects the counter
            if (r.taken) begin
                if (ctr_model[cidx] != 2'd3)
                    ctr_model[cidx] = ctr_model[cidx] + 2'd1;
            end else if (ctr_model[cidx] != 2'd0) begin
                ctr_model[cidx] = ctr_model[cidx] - 2'd1;
            end
            hist_model[idx]   = {hist_model[idx][`BPU_HIST_BITS-2:0], r.taken};
            valid_model[idx]  = r.taken;
            target_model[idx] = r.taken ? r.target : r.pc + 32'd4;
            total_model       = total_model + 32'd1;
            if (r.correct)
                correct_model = correct_model + 32'd1;
        end
    endtask

    function automatic bpu_types_pkg::resolve_t random_resolve();
        bpu_types_pkg::resolve_t r;
        r.valid   = ($urandom % 10) < 6;
        r.pc      = pc_pool[int'($urandom % 8)];
        r.taken   = 1'($urandom);
        r.target  = $urandom & 32'hFFFF_FFFC;
        r.correct = 1'($urandom);
        return r;
    endfunction

    // one fetch and one resolve, prediction checked before the resolve lands
    task automatic drive_cycle(input bpu_types_pkg::pc_t f, input bpu_types_pkg::resolve_t r);
        bpu_types_pkg::prediction_t exp;
        @(posedge clk);
        fetch_pc <= f;
        resolve  <= r;
        @(negedge clk);
        exp = expected_prediction(f);
        check_value("prediction.taken", 32'(prediction.taken), 32'(exp.taken));
        check_value("prediction.target", prediction.target, exp.target);
        apply_resolve(r);
    endtask

    task automatic apb_transfer(input logic write, input bpu_apb_pkg::stat_addr_t addr,
                                input logic [31:0] wdata, output logic [31:0] data,
                                output logic err);
        bpu_apb_pkg::apb_req_t req;
        int                    waited;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        resolve <= NO_RESOLVE;    // bus traffic runs with execute quiet
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        waited = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (apb_rsp.pready) begin
            data = apb_rsp.prdata;
            err  = apb_rsp.pslverr;
        end else begin
            error_count++;
            $display("APB timeout: no pready from the slave for offset %h", addr);
            data = '0;
            err  = 1'b0;
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    initial begin
        bpu_types_pkg::resolve_t rsv;
        bpu_types_pkg::pc_t      pc;
        bpu_types_pkg::pc_t      branch_target;
        clk = 1'b0;
        reset = 1'b1;
        fetch_pc = '0;
        resolve = NO_RESOLVE;
        apb_req = '0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        test_start_errors = 0;
        void'($urandom(76));
        for (int i = 0; i < ENTRIES; i++) begin
            hist_model[i]   = '0;
            ctr_model[i]    = bpu_types_pkg::sat_ctr_t'(`BPU_CTR_INIT);
            valid_model[i]  = 1'b0;
            target_model[i] = '0;
        end
        total_model = '0;
        correct_model = '0;
        for (int i = 0; i < 8; i++)
            pc_pool[i] = ($urandom & 32'hFFFF_F000) | 32'h100 | (32'(i % 4) << 2);
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 20; i++) begin
            pc = $urandom & 32'hFFFF_FFFC;
            drive_cycle(pc, NO_RESOLVE);
            check_value("prediction.taken", 32'(prediction.taken), 32'd0);
            check_value("prediction.target", prediction.target, pc + 32'd4);
        end
        check_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'd0);
        check_value("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'd0);
        check_value("apb_rsp.prdata", apb_rsp.prdata, 32'd0);
        apb_transfer(1'b0, `STATS_TOTAL_ADDR, '0, rdata, slverr);
        check_value("total count", rdata, 32'd0);
        apb_transfer(1'b0, `STATS_CORRECT_ADDR, '0, rdata, slverr);
        check_value("correct count", rdata, 32'd0);
        end_test("reset state");

        pc = pc_pool[0];
        branch_target = 32'h0004_2000;
        rsv = '{valid: 1'b1, pc: pc, taken: 1'b1, target: branch_target, correct: 1'b1};
        repeat (4) drive_cycle(pc, rsv);
        drive_cycle(pc, NO_RESOLVE);
        check_value("prediction.taken", 32'(prediction.taken), 32'd1);
        check_value("prediction.target", prediction.target, branch_target);
        rsv.taken = 1'b0;
        rsv.correct = 1'b0;
        drive_cycle(pc, rsv);
        drive_cycle(pc, NO_RESOLVE);
        check_value("prediction.taken", 32'(prediction.taken), 32'd0);
        check_value("prediction.target", prediction.target, pc + 32'd4);
        end_test("single branch training");

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (($urandom % 4) != 0)
                pc = pc_pool[int'($urandom % 8)];
            else
                pc = $urandom & 32'hFFFF_FFFC;
            drive_cycle(pc, random_resolve());
        end
        end_test("random fetch and resolve");

        apb_transfer(1'b0, `STATS_TOTAL_ADDR, '0, rdata, slverr);
        check_value("total count", rdata, total_model);
        check_value("apb_rsp.pslverr", 32'(slverr), 32'd0);
        apb_transfer(1'b0, `STATS_CORRECT_ADDR, '0, rdata, slverr);
        check_value("correct count", rdata, correct_model);
        end_test("statistics after random run");

        apb_transfer(1'b1, `STATS_CTRL_ADDR, 32'd1, rdata, slverr);
        check_value("apb_rsp.pslverr", 32'(slverr), 32'd0);
        total_model = '0;
        correct_model = '0;
        apb_transfer(1'b0, `STATS_TOTAL_ADDR, '0, rdata, slverr);
        check_value("total count", rdata, 32'd0);
        apb_transfer(1'b0, `STATS_CORRECT_ADDR, '0, rdata, slverr);
        check_value("correct count", rdata, 32'd0);
        apb_transfer(1'b0, `STATS_CTRL_ADDR, '0, rdata, slverr);
        check_value("control read", rdata, 32'd0);
        for (int i = 0; i < 8; i++)
            drive_cycle(pc_pool[i], NO_RESOLVE);    // tables untouched by the clear
        end_test("statistics clear");

        repeat (10) drive_cycle(pc_pool[int'($urandom % 8)], random_resolve());
        apb_transfer(1'b0, 4'hC, '0, rdata, slverr);
        check_value("apb_rsp.pslverr", 32'(slverr), 32'd1);
        apb_transfer(1'b1, 4'h2, 32'd1, rdata, slverr);
        check_value("apb_rsp.pslverr", 32'(slverr), 32'd1);
        apb_transfer(1'b0, `STATS_TOTAL_ADDR, '0, rdata, slverr);
        check_value("total count", rdata, total_model);
        apb_transfer(1'b0, `STATS_CORRECT_ADDR, '0, rdata, slverr);
        check_value("correct count", rdata, correct_model);
        end_test("undefined offset");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/bpu_types_pkg.sv
verilog/bpu_apb_pkg.sv
verilog/local_history_table.sv
verilog/pattern_table.sv
verilog/target_buffer.sv
verilog/prediction_stats.sv
verilog/branch_predictor_top.sv
tests/bpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module bpu_tb -o bpu_sim \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/bpu_sim > sim.log 2>&1
cat sim.log

grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
